//--- logic/clock_params.svh
// width and limit macros for the mm:ss display clock, included by the package and RTL
`ifndef CLOCK_PARAMS_SVH
`define CLOCK_PARAMS_SVH

// ------------------------------------------------------------------------
// digit and segment widths
// ------------------------------------------------------------------------
`define CLK_BCD_W      4     // one decimal digit
`define CLK_SEG_W      7     // segments a..g

// ------------------------------------------------------------------------
// digit limits for a 00..59 counter
// ------------------------------------------------------------------------
`define CLK_UNITS_MAX  9     // largest units digit
`define CLK_TENS_MAX   5     // largest tens digit, seconds and minutes

`endif

//--- logic/clock_pkg.sv
// types shared by the display clock RTL and testbench, import where the types are needed
`include "clock_params.svh"

package clock_pkg;

    // ------------------------------------------------------------------------
    // digits and segment patterns
    // ------------------------------------------------------------------------
    typedef logic [`CLK_BCD_W-1:0] bcd_digit_t;   // one BCD digit
    typedef logic [`CLK_SEG_W-1:0] seg7_t;        // bit 0 = a ... bit 6 = g, active high

    // value of one mod-60 counter
    typedef struct packed {
        bcd_digit_t tens;
        bcd_digit_t units;
    } bcd_pair_t;

    // ------------------------------------------------------------------------
    // full display state
    // ------------------------------------------------------------------------
    typedef struct packed {
        bcd_pair_t minutes;
        bcd_pair_t seconds;
    } clock_time_t;

    typedef struct packed {
        seg7_t min_tens;    // leftmost digit
        seg7_t min_units;
        seg7_t sec_tens;
        seg7_t sec_units;   // rightmost digit
    } seg_bank_t;

endpackage

//--- logic/mod60_counter.sv
// two-digit BCD counter 00..59, steps on i_advance and flags the wrap back to 00
`timescale 1ns/1ps
`include "clock_params.svh"

module mod60_counter (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_advance,  // one-cycle step request
    output clock_pkg::bcd_pair_t  o_value,
    output logic                  o_wrap      // high with the advance that leaves 59
);

    import clock_pkg::*;

    // ------------------------------------------------------------------------
    // digit limits
    // ------------------------------------------------------------------------
    localparam bcd_digit_t UNITS_MAX = bcd_digit_t'(`CLK_UNITS_MAX);
    localparam bcd_digit_t TENS_MAX  = bcd_digit_t'(`CLK_TENS_MAX);

    bcd_pair_t value_q;
    logic      units_at_max;
    logic      at_max;

    assign units_at_max = (value_q.units == UNITS_MAX);
    assign at_max       = units_at_max && (value_q.tens == TENS_MAX);   // reads 59

    // carry out to the next counter, same cycle as the advance
    assign o_wrap  = i_advance & at_max;
    assign o_value = value_q;

    // ------------------------------------------------------------------------
    // digit update
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            value_q <= '0;
        end else if (i_advance) begin
            if (at_max) begin
                value_q <= '0;                              // 59 -> 00
            end else if (units_at_max) begin
                value_q.units <= '0;                        // x9 -> (x+1)0
                value_q.tens  <= value_q.tens + 1'b1;
            end else begin
                value_q.units <= value_q.units + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    a_units_range : assert property (
        @(posedge i_clk) disable iff (i_rst)
        value_q.units <= UNITS_MAX
    ) else $error("units digit out of range: %0d", value_q.units);

    a_tens_range : assert property (
        @(posedge i_clk) disable iff (i_rst)
        value_q.tens <= TENS_MAX
    ) else $error("tens digit out of range: %0d", value_q.tens);

    // a wrap must land on 00 one edge later
    a_wrap_to_zero : assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_wrap |=> (o_value == '0)
    ) else $error("counter did not return to 00 after wrap");

endmodule

//--- logic/seg7_decoder.sv
// maps one BCD digit to an active-high seven-segment pattern, purely combinational
`timescale 1ns/1ps

module seg7_decoder (
    input  clock_pkg::bcd_digit_t  i_digit,
    output clock_pkg::seg7_t       o_seg     // bit 0 = a ... bit 6 = g
);

    // ------------------------------------------------------------------------
    // digit to pattern table, gfedcba
    // ------------------------------------------------------------------------
    always_comb begin
        case (i_digit)
            4'd0:    o_seg = 7'h3F;
            4'd1:    o_seg = 7'h06;   // b c
            4'd2:    o_seg = 7'h5B;
            4'd3:    o_seg = 7'h4F;
            4'd4:    o_seg = 7'h66;
            4'd5:    o_seg = 7'h6D;
            4'd6:    o_seg = 7'h7D;
            4'd7:    o_seg = 7'h07;   // a b c
            4'd8:    o_seg = 7'h7F;   // all on
            4'd9:    o_seg = 7'h6F;
            default: o_seg = 7'h00;   // 10..15 blank
        endcase
    end

endmodule

//--- logic/clock_top.sv
// mm:ss wall clock top, counts i_sec_pulse edges and drives four seven-segment digits
`timescale 1ns/1ps

module clock_top (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_sec_pulse,  // slow one-second strobe, plain level
    output clock_pkg::seg_bank_t    o_seg,
    output clock_pkg::clock_time_t  o_time        // counter state for leds and debug
);

    import clock_pkg::*;

    // ------------------------------------------------------------------------
    // rising edge detect on the strobe
    // ------------------------------------------------------------------------
    logic [1:0] pulse_tap;   // [0] newest sample
    logic       sec_tick;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            pulse_tap <= 2'b00;
        end else begin
            pulse_tap <= {pulse_tap[0], i_sec_pulse};
        end
    end

    // one cycle per edge, however long the pulse is held
    assign sec_tick = pulse_tap[0] & ~pulse_tap[1];

    // ------------------------------------------------------------------------
    // seconds and minutes counters
    // ------------------------------------------------------------------------
    bcd_pair_t sec_value;
    bcd_pair_t min_value;
    logic      sec_wrap;

    mod60_counter u_sec (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_advance (sec_tick),
        .o_value   (sec_value),
        .o_wrap    (sec_wrap)
    );

    mod60_counter u_min (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_advance (sec_wrap),   // carry lands on the same edge as 59 -> 00
        .o_value   (min_value),
        .o_wrap    ()            // no hours digit
    );

    assign o_time.minutes = min_value;
    assign o_time.seconds = sec_value;

    // ------------------------------------------------------------------------
    // segment decoders, right to left
    // ------------------------------------------------------------------------
    seg7_decoder u_seg_su (
        .i_digit (sec_value.units),
        .o_seg   (o_seg.sec_units)
    );

    seg7_decoder u_seg_st (
        .i_digit (sec_value.tens),
        .o_seg   (o_seg.sec_tens)
    );

    seg7_decoder u_seg_mu (
        .i_digit (min_value.units),
        .o_seg   (o_seg.min_units)
    );

    seg7_decoder u_seg_mt (
        .i_digit (min_value.tens),
        .o_seg   (o_seg.min_tens)
    );

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    a_tick_single : assert property (
        @(posedge i_clk) disable iff (i_rst)
        sec_tick |=> !sec_tick
    ) else $error("sec_tick high on two consecutive cycles");

endmodule

//--- tb/tb_clk_gen.sv
// free-running testbench clock source, instantiated once by the clock testbench
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD_NS = 5    // 10 ns period
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always begin
        #(HALF_PERIOD_NS) o_clk = ~o_clk;
    end

endmodule

//--- tb/tb_clock_top.sv
// self-checking testbench for the mm:ss display clock, run as the simulation top
`timescale 1ns/1ps

module tb_clock_top;

    import clock_pkg::*;

    // ------------------------------------------------------------------------
    // run length
    // ------------------------------------------------------------------------
    localparam int unsigned RESET_CYCLES     = 10;
    localparam int unsigned MID_RESET_CYCLES = 4;
    localparam int unsigned HELD_PULSES      = 3;
    localparam int unsigned WRAP_TARGET      = 3602;  // one full hour plus two seconds
    localparam int unsigned PULSES_BEFORE    = 75;    // into the second minute
    localparam int unsigned PULSES_AFTER     = 65;
    localparam int unsigned TOTAL_PULSES     = WRAP_TARGET + PULSES_BEFORE + PULSES_AFTER;
    localparam int unsigned MAX_PULSE_CYCLES = 8;     // 4 high plus 4 low at most
    localparam int unsigned TIMEOUT_CYCLES   = TOTAL_PULSES * MAX_PULSE_CYCLES + 20_000;

    logic        i_clk;
    logic        i_rst;
    logic        i_sec_pulse;
    seg_bank_t   o_seg;
    clock_time_t o_time;

    string       test_name;
    logic [31:0] lfsr_state = 32'h0dc3_6068;
    int unsigned rise_count = 0;      // rising edges driven since the last reset
    int unsigned rise_count_d1 = 0;
    int unsigned rise_count_d2 = 0;   // what the display shows this cycle
    int unsigned cycle_count = 0;

    logic [15:0] sec_units_seen = '0;
    logic [15:0] sec_tens_seen  = '0;
    logic [15:0] min_units_seen = '0;
    logic [15:0] min_tens_seen  = '0;
    logic        hour_wrap_seen = 1'b0;
    clock_time_t prev_time      = '0;

    tb_clk_gen u_clk_gen (
        .o_clk (i_clk)
    );

    clock_top i_clock_top (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_sec_pulse (i_sec_pulse),
        .o_seg       (o_seg),
        .o_time      (o_time)
    );

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic seg7_t digit_pattern(input bcd_digit_t digit);
        case (digit)
            4'd0:    return 7'h3F;
            4'd1:    return 7'h06;
            4'd2:    return 7'h5B;
            4'd3:    return 7'h4F;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6D;
            4'd6:    return 7'h7D;
            4'd7:    return 7'h07;
            4'd8:    return 7'h7F;
            4'd9:    return 7'h6F;
            default: return 7'h00;
        endcase
    endfunction

    function automatic clock_time_t expected_time(input int unsigned total);
        int unsigned wrapped;
        int unsigned secs;
        int unsigned mins;
        clock_time_t t;
        wrapped = total % 3600;      // no hours digit
        secs    = wrapped % 60;
        mins    = wrapped / 60;
        t.seconds.tens  = bcd_digit_t'(secs / 10);
        t.seconds.units = bcd_digit_t'(secs % 10);
        t.minutes.tens  = bcd_digit_t'(mins / 10);
        t.minutes.units = bcd_digit_t'(mins % 10);
        return t;
    endfunction

    function automatic seg_bank_t expected_segs(input int unsigned total);
        clock_time_t t;
        seg_bank_t   s;
        t = expected_time(total);
        s.min_tens  = digit_pattern(t.minutes.tens);
        s.min_units = digit_pattern(t.minutes.units);
        s.sec_tens  = digit_pattern(t.seconds.tens);
        s.sec_units = digit_pattern(t.seconds.units);
        return s;
    endfunction

    // edge driven at D is counted at D+2, so the model lags two edges
    always @(posedge i_clk) begin
        rise_count_d1 <= rise_count;
        rise_count_d2 <= rise_count_d1;
    end

    // ------------------------------------------------------------------------
    // random pulse lengths
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];  // taps 32 22 2 1
        return {state[30:0], feedback};
    endfunction

    function automatic logic [31:0] random_bits(input int unsigned count);
        logic [31:0] value;
        value = '0;
        for (int unsigned i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic send_pulse(input int unsigned high_cycles, input int unsigned low_cycles);
        @(posedge i_clk);
        i_sec_pulse <= 1'b1;
        rise_count  <= rise_count + 1;
        repeat (high_cycles) @(posedge i_clk);
        i_sec_pulse <= 1'b0;
        repeat (low_cycles - 1) @(posedge i_clk);
    endtask

    task automatic send_random_pulse();
        int unsigned high_cycles;
        int unsigned low_cycles;
        high_cycles = 1 + random_bits(2);
        low_cycles  = 1 + random_bits(2);
        send_pulse(high_cycles, low_cycles);
    endtask

    task automatic drive_until(input int unsigned target);
        while (rise_count < target) begin
            send_random_pulse();
        end
    endtask

    task automatic release_reset();
        @(posedge i_clk);
        i_rst <= 1'b0;
    endtask

    task automatic apply_reset(input int unsigned cycles);
        @(posedge i_clk);
        i_rst      <= 1'b1;
        rise_count <= 0;           // display restarts from 00:00
        repeat (cycles) @(posedge i_clk);
        i_rst <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH test=%s %s expected=%h actual=%h", test_name, what, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1, "output check failed");
    endtask

    a_time_match : assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_time == expected_time(rise_count_d2)
    ) else report_mismatch("o_time", 32'(expected_time($sampled(rise_count_d2))),
                           32'($sampled(o_time)));

    a_seg_match : assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_seg == expected_segs(rise_count_d2)
    ) else report_mismatch("o_seg", 32'(expected_segs($sampled(rise_count_d2))),
                           32'($sampled(o_seg)));

    // async reset clears the display before the next clock edge
    a_reset_time : assert property (
        @(posedge i_clk)
        (i_rst && cycle_count != 0) |-> (o_time == '0)
    ) else report_mismatch("reset o_time", 32'h0, 32'($sampled(o_time)));

    a_reset_seg : assert property (
        @(posedge i_clk)
        (i_rst && cycle_count != 0) |-> (o_seg == expected_segs(0))
    ) else report_mismatch("reset o_seg", 32'(expected_segs(0)), 32'($sampled(o_seg)));

    // which digit values the run has shown
    always @(posedge i_clk) begin
        if (!i_rst) begin
            sec_units_seen[o_time.seconds.units] <= 1'b1;
            sec_tens_seen[o_time.seconds.tens]   <= 1'b1;
            min_units_seen[o_time.minutes.units] <= 1'b1;
            min_tens_seen[o_time.minutes.tens]   <= 1'b1;
            if (prev_time == 16'h5959 && o_time == '0) begin
                hour_wrap_seen <= 1'b1;   // 59:59 -> 00:00
            end
        end
        prev_time <= o_time;
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, stimulus did not complete", cycle_count);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        i_rst       = 1'b1;
        i_sec_pulse = 1'b0;
        test_name   = "reset";
        repeat (RESET_CYCLES - 1) @(posedge i_clk);
        release_reset();
        repeat (3) @(posedge i_clk);

        test_name = "held_pulse";
        repeat (HELD_PULSES) send_pulse(4, 4);

        test_name = "units_carry";           // passes 09 -> 10
        drive_until(12);

        test_name = "minute_carry";          // passes 00:59 -> 01:00
        drive_until(62);

        test_name = "hour_wrap";
        drive_until(WRAP_TARGET);

        test_name = "mid_reset";
        repeat (PULSES_BEFORE) send_random_pulse();
        apply_reset(MID_RESET_CYCLES);
        repeat (PULSES_AFTER) send_random_pulse();
        repeat (4) @(posedge i_clk);

        if (!(&sec_units_seen[9:0] && &sec_tens_seen[5:0] && &min_units_seen[9:0]
              && &min_tens_seen[5:0] && hour_wrap_seen)) begin
            $display("stimulus never showed every digit value or the hour wrap");
            $display("ERRORS FOUND");
            $fatal(1, "incomplete run");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- sources.f
+incdir+logic
logic/clock_pkg.sv
logic/mod60_counter.sv
logic/seg7_decoder.sv
logic/clock_top.sv
tb/tb_clk_gen.sv
tb/tb_clock_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the clock testbench with Verilator, run it, and judge the log.

ROOT_DIR=$(cd "$(dirname "$0")" && pwd)
cd "$ROOT_DIR" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log
TOP=tb_clock_top

verilator --binary --timing --assert \
    -f sources.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if grep -q "ERRORS FOUND" "$LOG_FILE"; then
    echo "simulation failed, see $LOG_FILE"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

echo "simulation passed"
exit 0
